//--- hw/cpuPkg.sv
package cpuPkg;

    localparam int sliceCount = 4; // ALU lanes, 8 bits each

    typedef logic [31:0] dataWord;
    typedef logic [3:0] regIndex;
    typedef logic [7:0] sliceWord;

    // which block drives the internal bus
    typedef enum logic [2:0] {
        none,
        general,
        pc,
        mdr,
        z
    } busSource;

    typedef enum logic [2:0] {
        add,
        sub,
        andOp,
        orOp,
        xorOp,
        notOp,
        negOp,
        passB
    } aluOp;

    // one control step, as the sequencer would issue it
    typedef struct packed {
        busSource source;
        regIndex  readReg;
        regIndex  writeReg;
        logic     regWrite;
        logic     marLoad;
        logic     mdrLoad;
        logic     read;       // mdr takes memData instead of bus
        logic     irLoad;
        logic     pcLoad;
        logic     incPc;      // with pcLoad, pc takes pc + 1
        logic     yLoad;
        logic     zLoad;
        aluOp     op;
    } controlWord;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } aluFlags;

endpackage

//--- hw/registerFile.sv
module registerFile import cpuPkg::*; (
    input  logic    Clock,
    input  logic    rst,
    input  logic    writeEnable,
    input  regIndex writeReg,
    input  regIndex readReg,
    input  dataWord writeData,
    output dataWord readData
);

    dataWord regs [2**$bits(regIndex)]; // r0 is an ordinary register here

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < $size(regs); i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeReg] <= writeData;
        end
    end

    assign readData = regs[readReg]; // combinational read port

endmodule

//--- hw/memoryPort.sv
module memoryPort import cpuPkg::*; (
    input  logic    Clock,
    input  logic    rst,
    input  logic    marLoad,
    input  logic    mdrLoad,
    input  logic    read,
    input  logic    irLoad,
    input  logic    pcLoad,
    input  logic    incPc,
    input  dataWord bus,
    input  dataWord memData,
    output dataWord mar,
    output dataWord mdr,
    output dataWord pc,
    output dataWord ir
);

    dataWord pcNext;
    dataWord mdrIn;

    assign pcNext = pc + 32'd1;
    assign mdrIn  = read ? memData : bus; // memory read wins over the bus

    always_ff @(posedge Clock) begin
        if (rst) begin
            mar <= '0;
            mdr <= '0;
            pc  <= '0;
            ir  <= '0;
        end else begin
            if (marLoad) begin
                mar <= bus;
            end
            if (mdrLoad) begin
                mdr <= mdrIn;
            end
            if (irLoad) begin
                ir <= bus;
            end
            if (pcLoad) begin
                pc <= incPc ? pcNext : bus; // incPc alone does nothing
            end
        end
    end

endmodule

//--- hw/operandStage.sv
module operandStage import cpuPkg::*; (
    input  logic    Clock,
    input  logic    rst,
    input  logic    yLoad,
    input  aluOp    op,
    input  dataWord bus,
    output dataWord operandA,
    output dataWord operandB,
    output logic    carryIn
);

    dataWord y;

    always_ff @(posedge Clock) begin
        if (rst) begin
            y <= '0;
        end else if (yLoad) begin
            y <= bus;
        end
    end

    // reduce sub, neg and not to add or pass in the slices
    always_comb begin
        operandA = y;
        operandB = bus;
        carryIn  = 1'b0;
        case (op)
            sub: begin
                operandB = ~bus;
                carryIn  = 1'b1; // y + ~bus + 1
            end
            negOp: begin
                operandA = '0;
                operandB = ~bus;
                carryIn  = 1'b1;
            end
            notOp: operandB = ~bus; // slices pass b through
            default: operandB = bus;
        endcase
    end

endmodule

//--- hw/aluSlice.sv
module aluSlice import cpuPkg::*; (
    input  aluOp     op,
    input  sliceWord a,
    input  sliceWord b,
    input  logic     carryIn,
    output sliceWord result,
    output logic     carryOut
);

    sliceWord sum;
    logic     sumCarry;

    assign {sumCarry, sum} = {1'b0, a} + {1'b0, b} + carryIn;

    always_comb begin
        carryOut = 1'b0;
        case (op)
            add, sub, negOp: begin
                result   = sum; // operands already conditioned upstream
                carryOut = sumCarry;
            end
            andOp: result = a & b;
            orOp: result = a | b;
            xorOp: result = a ^ b;
            default: result = b; // notOp and passB
        endcase
    end

endmodule

//--- hw/resultStage.sv
module resultStage import cpuPkg::*; (
    input  logic    Clock,
    input  logic    rst,
    input  logic    zLoad,
    input  aluOp    op,
    input  dataWord sliceResults,
    input  logic    lastCarry,
    output dataWord z,
    output aluFlags flags
);

    logic arithOp;

    assign arithOp = op inside {add, sub, negOp};

    always_ff @(posedge Clock) begin
        if (rst) begin
            z     <= '0;
            flags <= '0;
        end else if (zLoad) begin
            z              <= sliceResults;
            flags.zero     <= (sliceResults == '0);
            flags.negative <= sliceResults[$bits(dataWord)-1];
            flags.carry    <= arithOp & lastCarry; // logic ops clear carry
        end
    end

endmodule

//--- hw/busMux.sv
module busMux import cpuPkg::*; (
    input  busSource source,
    input  dataWord  general,
    input  dataWord  pc,
    input  dataWord  mdr,
    input  dataWord  z,
    output dataWord  bus
);

    // enum literals are scoped since the ports share their names
    always_comb begin
        case (source)
            cpuPkg::general: bus = general;
            cpuPkg::pc: bus = pc;
            cpuPkg::mdr: bus = mdr;
            cpuPkg::z: bus = z;
            default: bus = '0; // none leaves the bus at zero
        endcase
    end

endmodule

//--- hw/datapath.sv
module datapath import cpuPkg::*; (
    input  logic       Clock,
    input  logic       rst,
    input  controlWord ctrl,
    input  dataWord    memData,
    output dataWord    bus,
    output dataWord    memAddress,
    output dataWord    instruction,
    output aluFlags    flags
);

    dataWord generalValue;
    dataWord pcValue;
    dataWord mdrValue;
    dataWord zValue;
    dataWord operandA;
    dataWord operandB;
    dataWord sliceResults;
    logic [sliceCount:0] carry; // ripple chain, carry[0] from the operand stage

    registerFile regFile (
        .Clock(Clock),
        .rst(rst),
        .writeEnable(ctrl.regWrite),
        .writeReg(ctrl.writeReg),
        .readReg(ctrl.readReg),
        .writeData(bus),
        .readData(generalValue)
    );

    memoryPort memPort (
        .Clock(Clock),
        .rst(rst),
        .marLoad(ctrl.marLoad),
        .mdrLoad(ctrl.mdrLoad),
        .read(ctrl.read),
        .irLoad(ctrl.irLoad),
        .pcLoad(ctrl.pcLoad),
        .incPc(ctrl.incPc),
        .bus(bus),
        .memData(memData),
        .mar(memAddress),
        .mdr(mdrValue),
        .pc(pcValue),
        .ir(instruction)
    );

    operandStage operands (
        .Clock(Clock),
        .rst(rst),
        .yLoad(ctrl.yLoad),
        .op(ctrl.op),
        .bus(bus),
        .operandA(operandA),
        .operandB(operandB),
        .carryIn(carry[0])
    );

    for (genvar k = 0; k < sliceCount; k++) begin : gSlice
        aluSlice slice (
            .op(ctrl.op),
            .a(operandA[k*$bits(sliceWord) +: $bits(sliceWord)]),
            .b(operandB[k*$bits(sliceWord) +: $bits(sliceWord)]),
            .carryIn(carry[k]),
            .result(sliceResults[k*$bits(sliceWord) +: $bits(sliceWord)]),
            .carryOut(carry[k+1])
        );
    end

    resultStage results (
        .Clock(Clock),
        .rst(rst),
        .zLoad(ctrl.zLoad),
        .op(ctrl.op),
        .sliceResults(sliceResults),
        .lastCarry(carry[sliceCount]),
        .z(zValue),
        .flags(flags)
    );

    busMux mux (
        .source(ctrl.source),
        .general(generalValue),
        .pc(pcValue),
        .mdr(mdrValue),
        .z(zValue),
        .bus(bus)
    );

endmodule

//--- test/datapathAssertions.sv
module datapathAssertions import cpuPkg::*; (
    input logic    Clock,
    input logic    rst,
    input logic    zLoad,
    input dataWord z,
    input aluFlags flags
);

    timeunit 1ns;
    timeprecision 10ps;

    int   zeroErrors = 0;
    int   holdErrors = 0;
    int   resetErrors = 0;
    int   failures;
    logic loaded; // z written since reset, before that the zero flag is just cleared

    assign failures = zeroErrors + holdErrors + resetErrors;

    always_ff @(posedge Clock) begin
        if (rst) begin
            loaded <= 1'b0;
        end else if (zLoad) begin
            loaded <= 1'b1;
        end
    end

    zeroMatchesZ: assert property (@(posedge Clock) disable iff (rst)
        loaded |-> (flags.zero == (z == '0)))
        else begin
            zeroErrors++;
            $error("zero flag %b disagrees with z %h", flags.zero, z);
        end

    holdWithoutLoad: assert property (@(posedge Clock) disable iff (rst)
        !zLoad |=> ($stable(z) && $stable(flags)))
        else begin
            holdErrors++;
            $error("z or flags changed in a cycle without zLoad");
        end

    flagsClearAfterReset: assert property (@(posedge Clock) rst |=> (flags == '0))
        else begin
            resetErrors++;
            $error("flags %b not cleared after reset", flags);
        end

endmodule

//--- test/datapathTb.sv
module datapathTb import cpuPkg::*; ();

    timeunit 1ns;
    timeprecision 10ps;

    logic       Clock;
    logic       rst;
    controlWord ctrl;
    dataWord    memData;
    dataWord    bus;
    dataWord    memAddress;
    dataWord    instruction;
    aluFlags    flags;

    // fields of one stimulus line
    logic [2:0] srcField;
    regIndex    readField;
    regIndex    writeField;
    logic [8:0] loadBits;
    logic [2:0] opField;
    dataWord    memField;
    logic [3:0] maskField;
    dataWord    expBus;
    dataWord    expAddress;
    dataWord    expInstruction;
    logic [2:0] expFlags;

    int    fd;
    int    code;
    int    fields;
    int    lineCount;
    logic  finished;
    string text;

    datapath UUT (
        .Clock(Clock),
        .rst(rst),
        .ctrl(ctrl),
        .memData(memData),
        .bus(bus),
        .memAddress(memAddress),
        .instruction(instruction),
        .flags(flags)
    );

    bind resultStage datapathAssertions resultChecks (
        .Clock(Clock),
        .rst(rst),
        .zLoad(zLoad),
        .z(z),
        .flags(flags)
    );

    always #2 Clock = ~Clock;

    task automatic stopOnError(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at stimulus line %0d", lineCount);
    endtask

    task automatic compareValue(input string name, input dataWord actual,
                                input dataWord expected);
        if (actual !== expected) begin
            stopOnError($sformatf("mismatch %s at stimulus line %0d: got %h, expected %h",
                                  name, lineCount, actual, expected));
        end
    endtask

    task automatic applyLine();
        ctrl.source   = busSource'(srcField);
        ctrl.readReg  = readField;
        ctrl.writeReg = writeField;
        {ctrl.regWrite, ctrl.marLoad, ctrl.mdrLoad, ctrl.read, ctrl.irLoad,
         ctrl.pcLoad, ctrl.incPc, ctrl.yLoad, ctrl.zLoad} = loadBits;
        ctrl.op = aluOp'(opField);
        memData = memField;
    endtask

    task automatic checkLine();
        if (maskField[0]) begin
            compareValue("bus", bus, expBus);
        end
        if (maskField[1]) begin
            compareValue("memAddress", memAddress, expAddress);
        end
        if (maskField[2]) begin
            compareValue("instruction", instruction, expInstruction);
        end
        if (maskField[3]) begin
            compareValue("flags", {29'b0, flags}, {29'b0, expFlags});
        end
        if (UUT.results.resultChecks.failures != 0) begin
            stopOnError("an assertion on the result stage failed");
        end
    endtask

    initial begin
        Clock     = 1'b0;
        rst       = 1'b1;
        ctrl      = '0;
        memData   = '0;
        lineCount = 0;
        finished  = 1'b0;

        fd = $fopen("test/datapathStimulus.txt", "r");
        if (fd == 0) begin
            stopOnError("could not open test/datapathStimulus.txt for reading");
        end

        repeat (4) @(posedge Clock);
        #1;
        rst = 1'b0;

        // one pass per file line
        while (!finished) begin
            if (lineCount >= 200) begin
                stopOnError("stimulus file holds more than 200 lines");
            end
            code = $fgets(text, fd);
            lineCount++;
            if (code == 0) begin
                stopOnError("stimulus file ended before its end marker");
            end
            if (text.len() >= 3 && text.substr(0, 2) == "end") begin
                finished = 1'b1;
            end else if (text.len() > 1 && text[0] != "#") begin
                fields = $sscanf(text, "%h %h %h %b %h %h %h %h %h %h %b",
                                 srcField, readField, writeField, loadBits, opField,
                                 memField, maskField, expBus, expAddress,
                                 expInstruction, expFlags);
                if (fields != 11) begin
                    stopOnError($sformatf("stimulus line %0d has %0d fields instead of 11",
                                          lineCount, fields));
                end
                @(posedge Clock);
                #1;
                applyLine();
                #2; // one ns before the next edge
                checkLine();
            end
        end
        $fclose(fd);

        @(posedge Clock);
        #1;
        ctrl = '0;
        if (UUT.results.resultChecks.failures != 0) begin
            stopOnError("an assertion on the result stage failed");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- test/datapathStimulus.txt
# src rd wr loads(regWrite marLoad mdrLoad read irLoad pcLoad incPc yLoad zLoad) op memData
# mask(1 bus, 2 memAddress, 4 instruction, 8 flags) bus memAddress instruction flags(carry zero negative)
# reset and idle
0 0 0 000000000 0 00000000 F 00000000 00000000 00000000 000
1 5 0 000000000 0 00000000 9 00000000 00000000 00000000 000
# memory loads into r1 to r4
0 0 0 001100000 0 FFFFFFFF 1 00000000 00000000 00000000 000
3 0 1 100000000 0 00000000 1 FFFFFFFF 00000000 00000000 000
1 1 0 000000000 0 00000000 1 FFFFFFFF 00000000 00000000 000
0 0 0 001100000 0 00000001 1 00000000 00000000 00000000 000
3 0 2 100000000 0 00000000 1 00000001 00000000 00000000 000
1 2 0 000000000 0 00000000 1 00000001 00000000 00000000 000
0 0 0 001100000 0 12345678 1 00000000 00000000 00000000 000
3 0 3 100000000 0 00000000 1 12345678 00000000 00000000 000
1 3 0 000000000 0 00000000 1 12345678 00000000 00000000 000
0 0 0 001100000 0 0F0F0F0F 1 00000000 00000000 00000000 000
3 0 4 100000000 0 00000000 1 0F0F0F0F 00000000 00000000 000
1 4 0 000000000 0 00000000 1 0F0F0F0F 00000000 00000000 000
# mdr from the bus when read is clear
1 3 0 001000000 0 DEADBEEF 1 12345678 00000000 00000000 000
3 0 5 100000000 0 00000000 1 12345678 00000000 00000000 000
1 5 0 000000000 0 00000000 1 12345678 00000000 00000000 000
# fetch
1 4 0 000001000 0 00000000 1 0F0F0F0F 00000000 00000000 000
2 0 0 010001100 0 00000000 3 0F0F0F0F 00000000 00000000 000
0 0 0 001100000 0 A5A5C3C3 3 00000000 0F0F0F0F 00000000 000
3 0 0 000010000 0 00000000 5 A5A5C3C3 0F0F0F0F 00000000 000
2 0 0 000000000 0 00000000 7 0F0F0F10 0F0F0F0F A5A5C3C3 000
# add and sub
1 1 0 000000010 0 00000000 1 FFFFFFFF 00000000 00000000 000
1 2 0 000000001 0 00000000 9 00000001 00000000 00000000 000
4 0 0 000000000 0 00000000 9 00000000 00000000 00000000 110
1 3 0 000000010 0 00000000 1 12345678 00000000 00000000 000
1 4 0 000000001 0 00000000 9 0F0F0F0F 00000000 00000000 110
4 0 0 000000000 0 00000000 9 21436587 00000000 00000000 000
1 1 0 000000010 0 00000000 1 FFFFFFFF 00000000 00000000 000
1 3 0 000000001 0 00000000 9 12345678 00000000 00000000 000
4 0 0 000000000 0 00000000 9 12345677 00000000 00000000 100
1 3 0 000000010 0 00000000 1 12345678 00000000 00000000 000
1 4 0 000000001 1 00000000 9 0F0F0F0F 00000000 00000000 100
4 0 0 000000000 0 00000000 9 03254769 00000000 00000000 100
1 4 0 000000010 0 00000000 1 0F0F0F0F 00000000 00000000 000
1 3 0 000000001 1 00000000 9 12345678 00000000 00000000 100
4 0 0 000000000 0 00000000 9 FCDAB897 00000000 00000000 001
1 4 0 000000001 1 00000000 9 0F0F0F0F 00000000 00000000 001
4 0 0 000000000 0 00000000 9 00000000 00000000 00000000 110
# logic and unary ops, y holds r4
1 3 0 000000001 2 00000000 9 12345678 00000000 00000000 110
4 0 0 000000000 0 00000000 9 02040608 00000000 00000000 000
1 1 0 000000001 3 00000000 9 FFFFFFFF 00000000 00000000 000
4 0 0 000000000 0 00000000 9 FFFFFFFF 00000000 00000000 001
1 4 0 000000001 4 00000000 9 0F0F0F0F 00000000 00000000 001
4 0 0 000000000 0 00000000 9 00000000 00000000 00000000 010
1 3 0 000000001 5 00000000 9 12345678 00000000 00000000 010
4 0 0 000000000 0 00000000 9 EDCBA987 00000000 00000000 001
1 2 0 000000001 6 00000000 9 00000001 00000000 00000000 001
4 0 0 000000000 0 00000000 9 FFFFFFFF 00000000 00000000 001
1 0 0 000000001 6 00000000 9 00000000 00000000 00000000 001
4 0 0 000000000 0 00000000 9 00000000 00000000 00000000 110
1 3 0 000000001 7 00000000 9 12345678 00000000 00000000 110
4 0 0 000000000 0 00000000 9 12345678 00000000 00000000 000
# z holds without zLoad
0 0 0 000000000 1 00000000 9 00000000 00000000 00000000 000
4 0 0 000000000 0 00000000 9 12345678 00000000 00000000 000
4 0 0 000000000 0 00000000 F 12345678 0F0F0F0F A5A5C3C3 000
end

//--- compile.f
hw/cpuPkg.sv
hw/registerFile.sv
hw/memoryPort.sv
hw/operandStage.sv
hw/aluSlice.sv
hw/resultStage.sv
hw/busMux.sv
hw/datapath.sv
test/datapathAssertions.sv
test/datapathTb.sv

//--- Bender.yml
package:
  name: datapath

sources:
  - files:
      - hw/cpuPkg.sv
      - hw/registerFile.sv
      - hw/memoryPort.sv
      - hw/operandStage.sv
      - hw/aluSlice.sv
      - hw/resultStage.sv
      - hw/busMux.sv
      - hw/datapath.sv
  - target: test
    files:
      - test/datapathAssertions.sv
      - test/datapathTb.sv
